// File: compile.f
hdl/tx_pack.sv
hdl/clk_div_chain.sv
hdl/tx_cfg_port.sv
hdl/hr_16t4_mux.sv
hdl/qr_4t1_mux.sv
hdl/output_buf_tx.sv
hdl/tx_top.sv
tests/tx_top_assert.sv
tests/tb_tx_top.sv

// File: run.sh
#!/bin/sh
# Build and run the tx_top regression with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_tx_top \
    -o sim_tx_top

# The simulator status is not trusted alone, the log decides
./obj_dir/sim_tx_top > sim.log 2>&1 || true
cat sim.log

grep -q "Regression passed" sim.log

// File: tests/tb_tx_top.sv
`timescale 1ns/1ps

module tb_tx_top import tx_pack::*; ();

    logic              mdll_clk;
    logic              rst;
    logic [WORD_W-1:0] din;
    logic              cfg_req;
    tx_cfg_t           cfg;
    logic              cfg_ack;
    logic              clk_prbsgen;
    logic              dout_p;
    logic              dout_n;

    int seed = 18;
    int err_cnt;
    int test_cnt;
    int test_fail;
    int live_checks;            // Checks made with the driver on

    // Reference model state
    int                cyc;     // Cycle count since reset release
    logic              ack_q;
    logic              strobe_q;
    logic [WORD_W-1:0] din_q;
    tx_cfg_t           model_cfg; // Config the model believes is active
    tx_cfg_t           pend_cfg;  // Last value offered on the cfg port
    bit                exp_bit [int]; // Keyed by cycle
    tx_cfg_t           exp_cfg [int];

    tx_top dut0 (
        .mdll_clk    (mdll_clk),
        .rst         (rst),
        .din         (din),
        .cfg_req     (cfg_req),
        .cfg         (cfg),
        .cfg_ack     (cfg_ack),
        .clk_prbsgen (clk_prbsgen),
        .dout_p      (dout_p),
        .dout_n      (dout_n)
    );

    always #2 mdll_clk = ~mdll_clk; // 4 ns bit period

    // Place a sampled word's bits at their expected cycles, MSB first
    task automatic schedule_word(input logic [WORD_W-1:0] w, input tx_cfg_t c);
        int base;
        base = (cyc - 1) + TX_LAT + int'(c.phase); // Strobe was seen last cycle
        for (int i = 0; i < WORD_W; i++) begin
            exp_bit[base + i] = w[WORD_W-1-i];
            exp_cfg[base + i] = c; // Newer words overwrite on phase steps
        end
    endtask

    task automatic check_cycle();
        logic e_p;
        logic e_n;
        if (exp_bit.exists(cyc)) begin
            e_p = exp_cfg[cyc].drv_en & (exp_bit[cyc] ^ exp_cfg[cyc].invert);
            e_n = exp_cfg[cyc].drv_en ? ~e_p : 1'b0; // Complement only while driven
            if (exp_cfg[cyc].drv_en) live_checks++;
            if (dout_p !== e_p) begin
                $display("FAIL t=%0t dout_p expected %0b got %0b", $time, e_p, dout_p);
                err_cnt++;
            end
            if (dout_n !== e_n) begin
                $display("FAIL t=%0t dout_n expected %0b got %0b", $time, e_n, dout_n);
                err_cnt++;
            end
            exp_bit.delete(cyc);
            exp_cfg.delete(cyc);
        end
    endtask

    // Monitor at negedge, where everything is settled
    always @(negedge mdll_clk) begin
        if (rst) begin
            cyc       = 0;
            ack_q     = 1'b0;
            strobe_q  = 1'b0;
            model_cfg = CFG_RESET;
        end else begin
            cyc++;
            if (cfg_ack && !ack_q) model_cfg = pend_cfg; // Commit was at last strobe
            if (strobe_q) schedule_word(din_q, model_cfg);
            check_cycle();
            ack_q    = cfg_ack;
            strobe_q = clk_prbsgen;
            din_q    = din; // Value taken at the coming edge
        end
    end

    // Returns once clk_prbsgen is high, din is sampled at the next edge
    task automatic wait_strobe();
        int n;
        n = 0;
        @(negedge mdll_clk);
        while (!clk_prbsgen && n < 2 * WORD_W) begin
            @(negedge mdll_clk);
            n++;
        end
        if (!clk_prbsgen) begin
            $display("Timeout waiting for clk_prbsgen at t=%0t", $time);
            err_cnt++;
        end
    endtask

    // New random word right after each sampling edge
    task automatic send_words(input int n);
        for (int k = 0; k < n; k++) begin
            wait_strobe();
            @(posedge mdll_clk);
            din <= WORD_W'($random(seed));
        end
    endtask

    // Last word out plus deepest tap
    task automatic drain();
        repeat (WORD_W + TX_LAT + N_TAP + 1) @(posedge mdll_clk);
    endtask

    task automatic cfg_write(input tx_cfg_t c);
        int n;
        @(posedge mdll_clk);
        cfg      <= c;
        cfg_req  <= 1'b1;
        pend_cfg  = c;
        n = 0;
        while (!cfg_ack && n < WORD_W + 4) begin
            @(negedge mdll_clk);
            n++;
        end
        if (!cfg_ack) begin
            $display("Timeout waiting for cfg_ack to rise at t=%0t", $time);
            err_cnt++;
        end else if (n > WORD_W + 1) begin
            $display("cfg_ack took %0d cycles, more than 17", n);
            err_cnt++;
        end
        // Ack stays up as long as req does
        repeat (2) begin
            @(negedge mdll_clk);
            if (cfg_ack !== 1'b1) begin
                $display("FAIL t=%0t cfg_ack expected 1 got %0b", $time, cfg_ack);
                err_cnt++;
            end
        end
        @(posedge mdll_clk);
        cfg_req <= 1'b0;
        n = 0;
        while (cfg_ack && n < 4) begin
            @(negedge mdll_clk);
            n++;
        end
        if (cfg_ack) begin
            $display("Timeout waiting for cfg_ack to fall at t=%0t", $time);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        test_cnt++;
        if (err_cnt == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - err_before);
            test_fail++;
        end
    endtask

    // Driver off and no ack
    task automatic check_idle();
        if (dout_p !== 1'b0) begin
            $display("FAIL t=%0t dout_p expected 0 got %0b", $time, dout_p);
            err_cnt++;
        end
        if (dout_n !== 1'b0) begin
            $display("FAIL t=%0t dout_n expected 0 got %0b", $time, dout_n);
            err_cnt++;
        end
        if (cfg_ack !== 1'b0) begin
            $display("FAIL t=%0t cfg_ack expected 0 got %0b", $time, cfg_ack);
            err_cnt++;
        end
    endtask

    task automatic test_reset();
        int e0;
        int n;
        e0 = err_cnt;
        for (int i = 0; i < 5; i++) begin
            @(negedge mdll_clk);
            check_idle();
        end
        @(posedge mdll_clk);
        rst <= 1'b0;
        n = -1;
        while (n < 2 * WORD_W) begin
            @(negedge mdll_clk);
            n++;
            check_idle();
            if (clk_prbsgen) break;
        end
        if (!clk_prbsgen) begin
            $display("Timeout waiting for first clk_prbsgen");
            err_cnt++;
        end else if (n != WORD_W - 1) begin
            $display("First clk_prbsgen in cycle %0d after reset, expected 15", n);
            err_cnt++;
        end
        end_test("reset", e0);
    endtask

    task automatic test_serial();
        int e0;
        int l0;
        e0 = err_cnt;
        cfg_write('{phase: 2'd0, invert: 1'b0, drv_en: 1'b1});
        l0 = live_checks;
        send_words(8);
        drain();
        if (live_checks - l0 < 8 * WORD_W) begin
            $display("Too few bits checked on the serial stream");
            err_cnt++;
        end
        end_test("serial_order", e0);
    endtask

    task automatic test_phase();
        int e0;
        e0 = err_cnt;
        for (int p = 1; p < N_TAP; p++) begin
            cfg_write('{phase: p[PHASE_W-1:0], invert: 1'b0, drv_en: 1'b1});
            send_words(4);
            drain();
        end
        end_test("phase_delay", e0);
    endtask

    task automatic test_invert();
        int e0;
        e0 = err_cnt;
        cfg_write('{phase: 2'd0, invert: 1'b1, drv_en: 1'b1});
        send_words(4);
        drain();
        end_test("polarity_invert", e0);
    endtask

    task automatic test_disable();
        int e0;
        e0 = err_cnt;
        cfg_write('{phase: 2'd1, invert: 1'b0, drv_en: 1'b0}); // Both legs low
        send_words(3);
        drain();
        end_test("handshake_disable", e0);
    endtask

    initial begin
        mdll_clk    = 1'b0;
        rst         = 1'b1;
        din         = '0;
        cfg_req     = 1'b0;
        cfg         = CFG_RESET;
        pend_cfg    = CFG_RESET;
        err_cnt     = 0;
        test_cnt    = 0;
        test_fail   = 0;
        live_checks = 0;
        test_reset();
        test_serial();
        test_phase();
        test_invert();
        test_disable();
        $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tests/tx_top_assert.sv
`timescale 1ns/1ps

module tx_top_assert import tx_pack::*; (
    input wire logic mdll_clk,
    input wire logic rst,
    input wire logic cfg_req,
    input wire logic cfg_ack,
    input wire logic clk_prbsgen,
    input wire logic dout_p,
    input wire logic dout_n
);

    // Pair never both high, so either complementary or both off
    pair_ok: assert property (@(posedge mdll_clk) disable iff (rst)
        (dout_p || dout_n) |-> (dout_n == !dout_p))
        else $error("dout_n not complement of dout_p");

    // Ack only answers a live request
    ack_needs_req: assert property (@(posedge mdll_clk) disable iff (rst)
        $rose(cfg_ack) |-> cfg_req)
        else $error("cfg_ack rose without cfg_req");

    // Word strobe one cycle wide
    strobe_width: assert property (@(posedge mdll_clk) disable iff (rst)
        clk_prbsgen |=> !clk_prbsgen)
        else $error("clk_prbsgen wider than one cycle");

    // Next strobe one word later
    strobe_period: assert property (@(posedge mdll_clk) disable iff (rst)
        clk_prbsgen |-> ##WORD_W clk_prbsgen)
        else $error("clk_prbsgen period not one word");

endmodule

bind tx_top tx_top_assert tx_top_assert0 (.*);

// File: hdl/tx_top.sv
`timescale 1ns/1ps

module tx_top import tx_pack::*; (
    input  wire logic              mdll_clk,    // Bit clock, one bit per cycle
    input  wire logic              rst,         // Sync, active high
    input  wire logic [WORD_W-1:0] din,         // Held stable while clk_prbsgen is high
    input  wire logic              cfg_req,
    input  wire tx_cfg_t           cfg,
    output logic                   cfg_ack,
    output logic                   clk_prbsgen, // Word strobe to the data source
    output logic                   dout_p,
    output logic                   dout_n
);

    logic             qr_tick;    // Quarter-rate strobe
    logic [GRP_W-1:0] qr_data;    // Current nibble, MSB first
    logic             mtb;        // Mux to buffer, serial bit
    tx_cfg_t          cfg_active; // Committed config

    // Strobes in place of the divide-by-2 cascade
    clk_div_chain div0 (
        .mdll_clk    (mdll_clk),
        .rst         (rst),
        .qr_tick     (qr_tick),
        .clk_prbsgen (clk_prbsgen)
    );

    // Config handshake, commits on word boundary
    tx_cfg_port cfg0 (
        .mdll_clk    (mdll_clk),
        .rst         (rst),
        .cfg_req     (cfg_req),
        .cfg         (cfg),
        .clk_prbsgen (clk_prbsgen),
        .cfg_ack     (cfg_ack),
        .cfg_active  (cfg_active)
    );

    // 16 to 4
    hr_16t4_mux hr_mux_16t4_0 (
        .mdll_clk    (mdll_clk),
        .rst         (rst),
        .din         (din),
        .clk_prbsgen (clk_prbsgen),
        .qr_tick     (qr_tick),
        .qr_data     (qr_data)
    );

    // 4 to 1
    qr_4t1_mux qr_mux_4t1_0 (
        .mdll_clk (mdll_clk),
        .rst      (rst),
        .qr_data  (qr_data),
        .qr_tick  (qr_tick),
        .mtb      (mtb)
    );

    // Phase delay, polarity and differential driver
    output_buf_tx buf1 (
        .mdll_clk   (mdll_clk),
        .rst        (rst),
        .mtb        (mtb),
        .cfg_active (cfg_active),
        .dout_p     (dout_p),
        .dout_n     (dout_n)
    );

endmodule

// File: hdl/output_buf_tx.sv
`timescale 1ns/1ps

module output_buf_tx import tx_pack::*; (
    input  wire logic    mdll_clk,
    input  wire logic    rst,
    input  wire logic    mtb,        // Serial bit from qr mux
    input  wire tx_cfg_t cfg_active, // Changes on word strobe only
    output logic         dout_p,
    output logic         dout_n
);

    logic [N_TAP-1:0] dly;                          // Tap 0 is the output register
    tx_cfg_t          cfg_pipe [CFG_ALIGN+N_TAP-1]; // Config follows the data down the pipe
    tx_cfg_t          cfg_out;                      // Config at the pad
    logic             bit_sel;

    // Delay line, one bit period per tap
    always_ff @(posedge mdll_clk) begin
        dly <= {dly[N_TAP-2:0], mtb};
    end

    // Delay the config to the cycle where the new word's first bit reaches tap 0
    // Extra stages keep it while that bit walks down to the deepest tap
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            for (int i = 0; i < CFG_ALIGN+N_TAP-1; i++) begin
                cfg_pipe[i] <= CFG_RESET;
            end
        end else begin
            cfg_pipe[0] <= cfg_active;
            for (int i = 1; i < CFG_ALIGN+N_TAP-1; i++) begin
                cfg_pipe[i] <= cfg_pipe[i-1];
            end
        end
    end

    // Stage CFG_ALIGN-1+j holds a config whose first bit reached tap 0 j cycles ago
    // Newest config whose own phase has already brought its word to the pad
    // Deepest stage always qualifies, so the old word's tail keeps the old config
    always_comb begin
        cfg_out = cfg_pipe[CFG_ALIGN+N_TAP-2];
        for (int j = N_TAP-2; j >= 0; j--) begin
            if (int'(cfg_pipe[CFG_ALIGN-1+j].phase) <= j) begin
                cfg_out = cfg_pipe[CFG_ALIGN-1+j];
            end
        end
    end

    // Bit-slip by phase code, then polarity
    assign bit_sel = dly[cfg_out.phase] ^ cfg_out.invert;

    // Differential pair, both low when the driver is off
    assign dout_p = cfg_out.drv_en & bit_sel;
    assign dout_n = cfg_out.drv_en & ~bit_sel;

endmodule

// File: hdl/qr_4t1_mux.sv
`timescale 1ns/1ps

module qr_4t1_mux import tx_pack::*; (
    input  wire logic             mdll_clk,
    input  wire logic             rst,
    input  wire logic [GRP_W-1:0] qr_data, // Nibble from the hr mux
    input  wire logic             qr_tick, // Load strobe
    output logic                  mtb      // Serial bit to buffer
);

    logic [GRP_W-1:0] shreg;

    // Load on the tick, shift on the three cycles between
    // Bits leave back to back with no gap between groups
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            shreg <= '0;
        end else if (qr_tick) begin
            shreg <= qr_data;                         // MSB out next cycle
        end else begin
            shreg <= {shreg[GRP_W-2:0], 1'b0};        // Move next bit up
        end
    end

    assign mtb = shreg[GRP_W-1]; // MSB first

endmodule

// File: hdl/hr_16t4_mux.sv
`timescale 1ns/1ps

module hr_16t4_mux import tx_pack::*; (
    input  wire logic              mdll_clk,
    input  wire logic              rst,
    input  wire logic [WORD_W-1:0] din,
    input  wire logic              clk_prbsgen, // Sample din at end of this cycle
    input  wire logic              qr_tick,     // Advance to next nibble
    output logic      [GRP_W-1:0]  qr_data
);

    // Word held as nibbles, group 0 goes out first
    logic [N_GRP-1:0][GRP_W-1:0] word_q;
    logic [GRP_SEL_W-1:0]        grp_ptr; // Nibble on qr_data

    // Reorder into MSB-first groups
    // Group g carries din[15-4g] down to din[12-4g]
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            word_q <= '0; // Keeps the idle stream defined
        end else if (clk_prbsgen) begin
            for (int g = 0; g < N_GRP; g++) begin
                word_q[g] <= din[WORD_W-1-g*GRP_W -: GRP_W];
            end
        end
    end

    // Group pointer
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            grp_ptr <= '0;
        end else if (clk_prbsgen) begin
            grp_ptr <= '0;             // Realign with each new word
        end else if (qr_tick) begin
            grp_ptr <= grp_ptr + 1'b1; // Next nibble, wraps after the last
        end
    end

    // Valid at each qr_tick, first group one cycle after the word is sampled
    assign qr_data = word_q[grp_ptr];

endmodule

// File: hdl/tx_cfg_port.sv
`timescale 1ns/1ps

module tx_cfg_port import tx_pack::*; (
    input  wire logic    mdll_clk,
    input  wire logic    rst,
    input  wire logic    cfg_req,     // Four-phase request
    input  wire tx_cfg_t cfg,         // Stable while cfg_req high
    input  wire logic    clk_prbsgen, // Word boundary
    output logic         cfg_ack,
    output tx_cfg_t      cfg_active   // Applied config
);

    cfg_state_e state;
    tx_cfg_t    cfg_pend; // Taken on req, waits for boundary

    // Handshake FSM and active config
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            state      <= CFG_IDLE;
            cfg_active <= CFG_RESET; // Driver off after reset
        end else begin
            case (state)
                CFG_IDLE: begin
                    if (cfg_req) begin
                        state <= CFG_PEND;
                    end
                end
                CFG_PEND: begin
                    // Only change on the word strobe, never mid-word
                    if (clk_prbsgen) begin
                        cfg_active <= cfg_pend;
                        state      <= CFG_ACK;
                    end
                end
                CFG_ACK: begin
                    if (!cfg_req) begin
                        state <= CFG_IDLE; // Ack drops next cycle
                    end
                end
                default: begin
                    state <= CFG_IDLE;
                end
            endcase
        end
    end

    // Capture request payload
    always_ff @(posedge mdll_clk) begin
        if (state == CFG_IDLE && cfg_req) begin
            cfg_pend <= cfg;
        end
    end

    assign cfg_ack = (state == CFG_ACK); // Straight from state, glitch free

endmodule

// File: hdl/clk_div_chain.sv
`timescale 1ns/1ps

module clk_div_chain import tx_pack::*; (
    input  wire logic mdll_clk,
    input  wire logic rst,
    output logic      qr_tick,     // Every GRP_W cycles
    output logic      clk_prbsgen  // Every WORD_W cycles
);

    // Free-running bit counter
    // Position within the word, 0 in the cycle after the word strobe
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1; // Wraps every word
        end
    end

    // Quarter-rate strobe on counts 0, 4, 8, 12
    // Lands one cycle after the word strobe so the first nibble is ready
    assign qr_tick = (cnt[TICK_W-1:0] == '0);

    // Word strobe on the last count, first in cycle 15 after reset
    assign clk_prbsgen = (cnt == '1);

endmodule

// File: hdl/tx_pack.sv
package tx_pack;

    // Data path widths
    localparam int WORD_W    = 16;                // Parallel word from data source
    localparam int GRP_W     = 4;                 // Quarter-rate group
    localparam int N_GRP     = WORD_W / GRP_W;    // Groups per word
    localparam int GRP_SEL_W = $clog2(N_GRP);     // Group pointer width

    // Divider chain
    localparam int CNT_W  = $clog2(WORD_W);       // One count per bit of a word
    localparam int TICK_W = $clog2(GRP_W);        // Low counter bits for qr strobe

    // Bit-delay standing in for the interpolators
    localparam int PHASE_W = 2;
    localparam int N_TAP   = 2**PHASE_W;          // Taps 0..3 bit periods

    // Sampling edge to first bit on dout_p, phase code 0
    localparam int TX_LAT = 3;
    // Config travels this many cycles behind the commit to meet the word's first bit
    localparam int CFG_ALIGN = TX_LAT - 1;

    typedef struct packed {
        logic [PHASE_W-1:0] phase;  // Whole bit periods of delay
        logic               invert; // Output polarity
        logic               drv_en; // Driver on
    } tx_cfg_t;

    // Driver off, no delay, normal polarity
    localparam tx_cfg_t CFG_RESET = '{phase: '0, invert: 1'b0, drv_en: 1'b0};

    // Four-phase config receiver
    typedef enum logic [1:0] {
        CFG_IDLE,   // Waiting for req
        CFG_PEND,   // Holding request until word boundary
        CFG_ACK     // Committed, ack high until req drops
    } cfg_state_e;

endpackage
